/* src/av_net_pkg.sv */
package av_net_pkg;

	// --------------------------------------------------
	// Header field values expected on the wire
	// --------------------------------------------------
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
	localparam logic [7:0]  IP_VER_IHL    = 8'h45;
	localparam logic [7:0]  IP_PROTO_UDP  = 8'h11;

	// Lane k listens on the last address byte plus k
	localparam logic [31:0] DST_IP_BASE   = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam logic [15:0] DST_UDP_PORT  = 16'd12345;

	// --------------------------------------------------
	// Byte offsets, counted from the first preamble byte
	// --------------------------------------------------
	localparam int BYTE_IDX_W = 11;

	localparam logic [BYTE_IDX_W-1:0] OFS_ETH_TYPE = 11'h014;
	localparam logic [BYTE_IDX_W-1:0] OFS_IP_VER   = 11'h016;
	localparam logic [BYTE_IDX_W-1:0] OFS_IP_PROTO = 11'h01f;
	localparam logic [BYTE_IDX_W-1:0] OFS_IP_DST   = 11'h026;
	localparam logic [BYTE_IDX_W-1:0] OFS_UDP_DST  = 11'h02c;
	localparam logic [BYTE_IDX_W-1:0] OFS_INFO     = 11'h032;
	localparam logic [BYTE_IDX_W-1:0] OFS_PAYLOAD  = 11'h033;

	// Index of the last payload byte that is still taken
	localparam logic [BYTE_IDX_W-1:0] PAYLOAD_END  = 11'd1332;

endpackage

/* src/av_stream_pkg.sv */
package av_stream_pkg;

	// --------------------------------------------------
	// Lane and buffer sizing
	// --------------------------------------------------
	localparam int LANE_COUNT = 4;
	localparam int LANE_W     = 2;
	localparam int FIFO_DEPTH = 8;

	// Packet info byte codes
	localparam logic [7:0] KIND_VIDEO = 8'h00;
	localparam logic [7:0] KIND_AUDIO = 8'h01;

	// Word kind bit carried next to every output word
	localparam logic WORD_KIND_VIDEO = 1'b0;
	localparam logic WORD_KIND_AUDIO = 1'b1;

	// --------------------------------------------------
	// Output word, read as a pixel pair or as a sample
	// --------------------------------------------------
	typedef union packed {
		struct packed {
			logic [1:0]  field;
			logic [10:0] line_num;
			logic [7:0]  pix_hi;
			logic [7:0]  pix_lo;
		} video;
		struct packed {
			logic [16:0] pad;
			logic [11:0] sample;
		} audio;
	} stream_word_u;

endpackage

/* src/gmii_rx_align.sv */
`timescale 1ns/1ps

module gmii_rx_align (
	input  logic                              clk125,
	input  logic                              sys_rst,
	input  logic [7:0]                        rxd,
	input  logic                              rx_dv,
	output logic [7:0]                        byte_data,
	output logic [av_net_pkg::BYTE_IDX_W-1:0] byte_idx,
	output logic                              byte_valid
);

	import av_net_pkg::*;

	// Position of the byte now on rxd
	logic [BYTE_IDX_W-1:0] idx_cnt;

	// --------------------------------------------------
	// Frame position counter
	// --------------------------------------------------
	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			idx_cnt    <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= rx_dv;
			if (!rx_dv) begin
				idx_cnt <= '0;
			end else if (idx_cnt != '1) begin
				// Holds at the top so an oversize frame never wraps onto header offsets
				idx_cnt <= idx_cnt + 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// Broadcast byte and its index
	// --------------------------------------------------
	always_ff @(posedge clk125) begin
		byte_data <= rxd;
		byte_idx  <= idx_cnt;
	end

endmodule

/* src/av_packet_parser.sv */
`timescale 1ns/1ps

module av_packet_parser #(
	parameter int lane_index = 0
) (
	input  logic                              clk125,
	input  logic                              sys_rst,
	input  logic [7:0]                        byte_data,
	input  logic [av_net_pkg::BYTE_IDX_W-1:0] byte_idx,
	input  logic                              byte_valid,
	output av_stream_pkg::stream_word_u       lane_word,
	output logic                              lane_kind,
	output logic                              lane_push
);

	import av_net_pkg::*;
	import av_stream_pkg::*;

	// Captured header fields
	logic [15:0] eth_type;
	logic [7:0]  ip_ver;
	logic [7:0]  ip_proto;
	logic [31:0] ip_dst;
	logic [15:0] udp_dst;

	logic        dst_match;
	logic        hdr_match;

	// Accepted frame kind
	logic        vid_en;
	logic        aud_en;

	// Byte position inside a pixel pair or a sample group
	logic [1:0]  phase;

	logic        in_window;
	logic        info_byte;
	logic        line_lo_byte;
	logic        line_hi_byte;
	logic        pix_byte;
	logic        aud_byte;

	// Partial words
	logic [10:0] line_num;
	logic        field_flag;
	logic [7:0]  pix_hi;
	logic [7:0]  aud_b0;
	logic [3:0]  aud_nib;

	// --------------------------------------------------
	// Header capture
	// --------------------------------------------------
	always_ff @(posedge clk125) begin
		if (byte_valid) begin
			case (byte_idx)
				OFS_ETH_TYPE:          eth_type[15:8] <= byte_data;
				OFS_ETH_TYPE + 11'd1:  eth_type[7:0]  <= byte_data;
				OFS_IP_VER:            ip_ver         <= byte_data;
				OFS_IP_PROTO:          ip_proto       <= byte_data;
				OFS_IP_DST:            ip_dst[31:24]  <= byte_data;
				OFS_IP_DST + 11'd1:    ip_dst[23:16]  <= byte_data;
				OFS_IP_DST + 11'd2:    ip_dst[15:8]   <= byte_data;
				OFS_IP_DST + 11'd3:    ip_dst[7:0]    <= byte_data;
				OFS_UDP_DST:           udp_dst[15:8]  <= byte_data;
				OFS_UDP_DST + 11'd1:   udp_dst[7:0]   <= byte_data;
				default: ;
			endcase
		end
	end

	// Each lane owns one address above the base
	assign dst_match = (ip_dst[31:8] == DST_IP_BASE[31:8]) &&
		(ip_dst[7:0] == (DST_IP_BASE[7:0] + 8'(lane_index)));

	assign hdr_match = (eth_type == ETH_TYPE_IPV4) && (ip_ver == IP_VER_IHL) &&
		(ip_proto == IP_PROTO_UDP) && (udp_dst == DST_UDP_PORT) && dst_match;

	// PAYLOAD_END itself is the last byte taken
	assign in_window    = byte_valid && (byte_idx <= PAYLOAD_END);
	assign info_byte    = byte_valid && (byte_idx == OFS_INFO);
	assign line_lo_byte = in_window && vid_en && (byte_idx == OFS_PAYLOAD);
	assign line_hi_byte = in_window && vid_en && (byte_idx == OFS_PAYLOAD + 11'd1);
	assign pix_byte     = in_window && vid_en && (byte_idx > OFS_PAYLOAD + 11'd1);
	assign aud_byte     = in_window && aud_en && (byte_idx >= OFS_PAYLOAD);

	// --------------------------------------------------
	// Accept decision and push control
	// --------------------------------------------------
	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			vid_en    <= 1'b0;
			aud_en    <= 1'b0;
			phase     <= 2'd0;
			lane_push <= 1'b0;
		end else begin
			lane_push <= 1'b0;
			if (!byte_valid) begin
				// Partial pair or group lost at frame end
				vid_en <= 1'b0;
				aud_en <= 1'b0;
				phase  <= 2'd0;
			end else if (info_byte) begin
				vid_en <= hdr_match && (byte_data == KIND_VIDEO);
				aud_en <= hdr_match && (byte_data == KIND_AUDIO);
				phase  <= 2'd0;
			end
			if (pix_byte) begin
				phase     <= phase ^ 2'd1;
				lane_push <= phase[0];
			end
			if (aud_byte) begin
				phase     <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
				lane_push <= (phase != 2'd0);
			end
		end
	end

	// --------------------------------------------------
	// Word assembly
	// --------------------------------------------------
	always_ff @(posedge clk125) begin
		if (line_lo_byte) begin
			line_num[7:0] <= byte_data;
		end
		if (line_hi_byte) begin
			line_num[10:8] <= byte_data[2:0];
			// Only one field bit is sent on the wire
			field_flag     <= byte_data[4];
		end
		if (pix_byte) begin
			if (!phase[0]) begin
				pix_hi <= byte_data;
			end else begin
				lane_word.video.field    <= {1'b0, field_flag};
				lane_word.video.line_num <= line_num;
				lane_word.video.pix_hi   <= pix_hi;
				lane_word.video.pix_lo   <= byte_data;
				lane_kind                <= WORD_KIND_VIDEO;
			end
		end
		if (aud_byte) begin
			case (phase)
				2'd0: aud_b0 <= byte_data;
				2'd1: begin
					lane_word.audio.pad    <= '0;
					lane_word.audio.sample <= {byte_data[3:0], aud_b0};
					lane_kind              <= WORD_KIND_AUDIO;
					aud_nib                <= byte_data[7:4];
				end
				default: begin
					lane_word.audio.pad    <= '0;
					lane_word.audio.sample <= {byte_data, aud_nib};
					lane_kind              <= WORD_KIND_AUDIO;
				end
			endcase
		end
	end

endmodule

/* src/av_lane_merge.sv */
`timescale 1ns/1ps

module av_lane_merge (
	input  logic                                  clk125,
	input  logic                                  sys_rst,
	input  av_stream_pkg::stream_word_u           lane_word [av_stream_pkg::LANE_COUNT],
	input  logic [av_stream_pkg::LANE_COUNT-1:0]  lane_kind,
	input  logic [av_stream_pkg::LANE_COUNT-1:0]  lane_push,
	output av_stream_pkg::stream_word_u           out_word,
	output logic                                  out_kind,
	output logic [av_stream_pkg::LANE_W-1:0]      out_lane,
	output logic                                  out_valid,
	input  logic                                  out_ready,
	output logic [15:0]                           drop_count
);

	import av_stream_pkg::*;

	localparam int PTR_W  = $clog2(FIFO_DEPTH);
	localparam int FILL_W = PTR_W + 1;
	localparam int ENTRY_W = $bits(stream_word_u) + 1;

	// Kind bit stored above the word
	logic [ENTRY_W-1:0] mem [LANE_COUNT][FIFO_DEPTH];

	logic [PTR_W-1:0]  wr_ptr [LANE_COUNT];
	logic [PTR_W-1:0]  rd_ptr [LANE_COUNT];
	logic [FILL_W-1:0] fill   [LANE_COUNT];

	logic [LANE_COUNT-1:0] lane_full;
	logic [LANE_COUNT-1:0] lane_wr;
	logic [LANE_COUNT-1:0] lane_rd;

	logic [LANE_W-1:0] last_lane;
	logic [LANE_W-1:0] pick_lane;
	logic [LANE_W-1:0] cand;
	logic              pick_found;
	logic              take;

	logic [16:0]       drop_sum;

	// --------------------------------------------------
	// Round robin pick, starting after the last lane served
	// --------------------------------------------------
	always_comb begin
		pick_found = 1'b0;
		pick_lane  = last_lane;
		cand       = last_lane;
		for (int i = 1; i <= LANE_COUNT; i++) begin
			cand = LANE_W'((int'(last_lane) + i) % LANE_COUNT);
			if (!pick_found && (fill[cand] != '0)) begin
				pick_found = 1'b1;
				pick_lane  = cand;
			end
		end
	end

	// Output register is free or being emptied this cycle
	assign take = pick_found && (!out_valid || out_ready);

	always_comb begin
		drop_sum = {1'b0, drop_count};
		for (int l = 0; l < LANE_COUNT; l++) begin
			lane_full[l] = (fill[l] == FILL_W'(FIFO_DEPTH));
			lane_wr[l]   = lane_push[l] && !lane_full[l];
			lane_rd[l]   = take && (pick_lane == LANE_W'(l));
			drop_sum     = drop_sum + {16'd0, lane_push[l] && lane_full[l]};
		end
	end

	// --------------------------------------------------
	// Lane buffers
	// --------------------------------------------------
	always_ff @(posedge clk125) begin
		for (int l = 0; l < LANE_COUNT; l++) begin
			if (lane_wr[l]) begin
				mem[l][wr_ptr[l]] <= {lane_kind[l], lane_word[l]};
			end
		end
	end

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			for (int l = 0; l < LANE_COUNT; l++) begin
				wr_ptr[l] <= '0;
				rd_ptr[l] <= '0;
				fill[l]   <= '0;
			end
			out_valid  <= 1'b0;
			last_lane  <= '0;
			drop_count <= '0;
		end else begin
			for (int l = 0; l < LANE_COUNT; l++) begin
				if (lane_wr[l]) begin
					wr_ptr[l] <= wr_ptr[l] + 1'b1;
				end
				if (lane_rd[l]) begin
					rd_ptr[l] <= rd_ptr[l] + 1'b1;
				end
				if (lane_wr[l] && !lane_rd[l]) begin
					fill[l] <= fill[l] + 1'b1;
				end else if (!lane_wr[l] && lane_rd[l]) begin
					fill[l] <= fill[l] - 1'b1;
				end
			end
			if (take) begin
				out_valid <= 1'b1;
				last_lane <= pick_lane;
			end else if (out_ready) begin
				out_valid <= 1'b0;
			end
			// Saturates at the top
			drop_count <= drop_sum[16] ? 16'hffff : drop_sum[15:0];
		end
	end

	// Output stage holds its word until accepted
	always_ff @(posedge clk125) begin
		if (take) begin
			{out_kind, out_word} <= mem[pick_lane][rd_ptr[pick_lane]];
			out_lane             <= pick_lane;
		end
	end

endmodule

/* src/gmii_av_rx.sv */
`timescale 1ns/1ps

module gmii_av_rx (
	input  logic                             clk125,
	input  logic                             sys_rst,
	input  logic [7:0]                       rxd,
	input  logic                             rx_dv,
	output av_stream_pkg::stream_word_u      out_word,
	output logic                             out_kind,
	output logic [av_stream_pkg::LANE_W-1:0] out_lane,
	output logic                             out_valid,
	input  logic                             out_ready,
	output logic [15:0]                      drop_count
);

	import av_net_pkg::*;
	import av_stream_pkg::*;

	// Broadcast from the aligner
	logic [7:0]            byte_data;
	logic [BYTE_IDX_W-1:0] byte_idx;
	logic                  byte_valid;

	// Parser outputs, one per lane
	stream_word_u          lane_word [LANE_COUNT];
	logic [LANE_COUNT-1:0] lane_kind;
	logic [LANE_COUNT-1:0] lane_push;

	gmii_rx_align gmii_rx_align_i (
		.clk125     (clk125),
		.sys_rst    (sys_rst),
		.rxd        (rxd),
		.rx_dv      (rx_dv),
		.byte_data  (byte_data),
		.byte_idx   (byte_idx),
		.byte_valid (byte_valid)
	);

	for (genvar k = 0; k < LANE_COUNT; k++) begin : g_lane
		av_packet_parser #(
			.lane_index (k)
		) av_packet_parser_i (
			.clk125     (clk125),
			.sys_rst    (sys_rst),
			.byte_data  (byte_data),
			.byte_idx   (byte_idx),
			.byte_valid (byte_valid),
			.lane_word  (lane_word[k]),
			.lane_kind  (lane_kind[k]),
			.lane_push  (lane_push[k])
		);
	end

	av_lane_merge av_lane_merge_i (
		.clk125     (clk125),
		.sys_rst    (sys_rst),
		.lane_word  (lane_word),
		.lane_kind  (lane_kind),
		.lane_push  (lane_push),
		.out_word   (out_word),
		.out_kind   (out_kind),
		.out_lane   (out_lane),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.drop_count (drop_count)
	);

endmodule

/* dv/gmii_av_rx_tb.sv */
`timescale 1ns/1ps

module gmii_av_rx_tb;

	import av_net_pkg::*;
	import av_stream_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DELAY  = 10;
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES  = 12;
	localparam int DRAIN_CYCLES = 200;
	localparam int MAX_FRAMES   = 64;
	// Payload end plus four FCS bytes
	localparam int FRAME_BYTES  = int'(PAYLOAD_END) + 5;
	localparam logic [31:0] LFSR_SEED = 32'h3336_b6d7;

	// Vector file columns
	localparam int C_OFS    = 0;
	localparam int C_PORT   = 1;
	localparam int C_ETYPE  = 2;
	localparam int C_PROTO  = 3;
	localparam int C_KIND   = 4;
	localparam int C_LINE   = 5;
	localparam int C_FIELD  = 6;
	localparam int C_SEED   = 7;
	localparam int C_MODE   = 8;
	localparam int C_ACCEPT = 9;
	localparam int C_CUT    = 10;
	localparam int NUM_COLS = 11;

	logic              clk125;
	logic              sys_rst;
	logic [7:0]        rxd;
	logic              rx_dv;
	stream_word_u      out_word;
	logic              out_kind;
	logic [LANE_W-1:0] out_lane;
	logic              out_valid;
	logic              out_ready;
	logic [15:0]       drop_count;

	int          vec [MAX_FRAMES][NUM_COLS];
	int          n_frames = 0;
	bit          vectors_loaded = 1'b0;
	logic [7:0]  frame_buf [FRAME_BYTES];
	int          frame_len;
	logic [29:0] exp_q [LANE_COUNT][$];
	logic [29:0] mon_entry;
	logic [31:0] ready_lfsr;
	int          exp_drops = 0;
	int          check_errors = 0;
	int          other_errors = 0;

	gmii_av_rx gmii_av_rx_i (
		.clk125     (clk125),
		.sys_rst    (sys_rst),
		.rxd        (rxd),
		.rx_dv      (rx_dv),
		.out_word   (out_word),
		.out_kind   (out_kind),
		.out_lane   (out_lane),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.drop_count (drop_count)
	);

	initial begin
		clk125 = 1'b0;
		forever #(CLK_PERIOD / 2) clk125 = ~clk125;
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(inout logic [31:0] state, input int count, output logic [7:0] bits);
		bits = 8'h00;
		for (int n = 0; n < count; n++) begin
			state = lfsr_next(state);
			bits  = {bits[6:0], state[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
			check_errors++;
		end
	endtask

	task automatic load_vectors();
		int    fd;
		int    rc;
		string line_str;
		fd = $fopen("dv/gmii_av_rx_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vectors file");
			other_errors++;
		end else begin
			while (!$feof(fd) && n_frames < MAX_FRAMES) begin
				line_str = "";
				rc = $fgets(line_str, fd);
				if (rc > 0 && line_str.len() > 1 && line_str.getc(0) != "#") begin
					rc = $sscanf(line_str, "%h %h %h %h %h %h %h %h %d %d %d",
						vec[n_frames][0], vec[n_frames][1], vec[n_frames][2],
						vec[n_frames][3], vec[n_frames][4], vec[n_frames][5],
						vec[n_frames][6], vec[n_frames][7], vec[n_frames][8],
						vec[n_frames][9], vec[n_frames][10]);
					if (rc != NUM_COLS) begin
						$display("Vectors file has a malformed line: %s", line_str);
						other_errors++;
					end else begin
						n_frames++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// --------------------------------------------------
	// Frame assembly and expected words
	// --------------------------------------------------
	task automatic build_frame(input int f);
		logic [31:0] pay_lfsr;
		logic [7:0]  rnd;
		pay_lfsr = LFSR_SEED ^ 32'(vec[f][C_SEED]);
		for (int i = 0; i < FRAME_BYTES; i++) begin
			frame_buf[i] = 8'h00;
		end
		for (int i = 0; i < 7; i++) begin
			frame_buf[i] = 8'h55;
		end
		frame_buf[7] = 8'hd5;
		// Destination and source MAC
		for (int i = 0; i < 12; i++) begin
			frame_buf[8 + i] = 8'(8'h10 + i);
		end
		frame_buf[OFS_ETH_TYPE]         = 8'(vec[f][C_ETYPE] >> 8);
		frame_buf[OFS_ETH_TYPE + 11'd1] = 8'(vec[f][C_ETYPE]);
		frame_buf[OFS_IP_VER]           = 8'h45;
		frame_buf[OFS_IP_PROTO - 11'd1] = 8'h40;
		frame_buf[OFS_IP_PROTO]         = 8'(vec[f][C_PROTO]);
		frame_buf[OFS_IP_DST]           = DST_IP_BASE[31:24];
		frame_buf[OFS_IP_DST + 11'd1]   = DST_IP_BASE[23:16];
		frame_buf[OFS_IP_DST + 11'd2]   = DST_IP_BASE[15:8];
		frame_buf[OFS_IP_DST + 11'd3]   = DST_IP_BASE[7:0] + 8'(vec[f][C_OFS]);
		frame_buf[OFS_UDP_DST - 11'd2]  = 8'h13;
		frame_buf[OFS_UDP_DST - 11'd1]  = 8'h88;
		frame_buf[OFS_UDP_DST]          = 8'(vec[f][C_PORT] >> 8);
		frame_buf[OFS_UDP_DST + 11'd1]  = 8'(vec[f][C_PORT]);
		frame_buf[OFS_INFO]             = 8'(vec[f][C_KIND]);
		// Payload and FCS from the LFSR
		for (int i = int'(OFS_PAYLOAD); i < FRAME_BYTES; i++) begin
			take_bits(pay_lfsr, 8, rnd);
			frame_buf[i] = rnd;
		end
		if (vec[f][C_KIND] == 0) begin
			frame_buf[OFS_PAYLOAD]         = 8'(vec[f][C_LINE]);
			frame_buf[OFS_PAYLOAD + 11'd1] = {3'b000, 1'(vec[f][C_FIELD]), 1'b0,
				3'(vec[f][C_LINE] >> 8)};
		end
		frame_len = (vec[f][C_CUT] == 0) ? FRAME_BYTES : vec[f][C_CUT];
	endtask

	task automatic queue_word(input int lane, input logic kind, input stream_word_u w,
			input int keep, inout int n_words);
		if (n_words < keep) begin
			exp_q[lane].push_back({kind, w});
		end
		n_words++;
	endtask

	task automatic expect_words(input int f);
		stream_word_u w;
		int           lane;
		int           last;
		int           keep;
		int           n_words;
		lane    = vec[f][C_OFS];
		n_words = 0;
		// A stalled output keeps one word in its register plus a full lane FIFO
		keep    = (vec[f][C_MODE] == 2) ? FIFO_DEPTH + 1 : FRAME_BYTES;
		last    = (frame_len - 1 < int'(PAYLOAD_END)) ? frame_len - 1 : int'(PAYLOAD_END);
		w       = '0;
		if (vec[f][C_ACCEPT] != 0 && lane >= LANE_COUNT) begin
			$display("Vector line %0d accepts a frame on a lane that does not exist", f);
			other_errors++;
		end else if (vec[f][C_ACCEPT] != 0 && vec[f][C_KIND] == 0) begin
			w.video.field    = 2'(vec[f][C_FIELD]);
			w.video.line_num = 11'(vec[f][C_LINE]);
			for (int i = int'(OFS_PAYLOAD) + 2; i + 1 <= last; i += 2) begin
				w.video.pix_hi = frame_buf[i];
				w.video.pix_lo = frame_buf[i + 1];
				queue_word(lane, 1'b0, w, keep, n_words);
			end
		end else if (vec[f][C_ACCEPT] != 0) begin
			// Group b0 b1 b2 gives {b1 low nibble, b0} then {b2, b1 high nibble}
			for (int i = int'(OFS_PAYLOAD); i + 1 <= last; i += 3) begin
				w.audio.sample = {frame_buf[i + 1][3:0], frame_buf[i]};
				queue_word(lane, 1'b1, w, keep, n_words);
				if (i + 2 <= last) begin
					w.audio.sample = {frame_buf[i + 2], frame_buf[i + 1][7:4]};
					queue_word(lane, 1'b1, w, keep, n_words);
				end
			end
		end
		if (n_words > keep) begin
			exp_drops += n_words - keep;
		end
	endtask

	// --------------------------------------------------
	// Stimulus and drain
	// --------------------------------------------------
	task automatic drive_frame(input int mode);
		logic [7:0] bits;
		int         stall_pos;
		stall_pos = -1;
		for (int i = 0; i < frame_len + IDLE_CYCLES; i++) begin
			@(posedge clk125);
			#(DRIVE_DELAY);
			if (i < frame_len) begin
				rxd   = frame_buf[i];
				rx_dv = 1'b1;
			end else begin
				rxd   = 8'h00;
				rx_dv = 1'b0;
			end
			if (mode == 1 && i % 4 == 0) begin
				take_bits(ready_lfsr, 2, bits);
				stall_pos = int'(bits[1:0]);
			end
			case (mode)
				1:       out_ready = (i % 4 != stall_pos);
				2:       out_ready = 1'b0;
				default: out_ready = 1'b1;
			endcase
		end
	endtask

	function automatic bit queues_empty();
		bit empty;
		empty = 1'b1;
		for (int l = 0; l < LANE_COUNT; l++) begin
			if (exp_q[l].size() != 0) begin
				empty = 1'b0;
			end
		end
		return empty;
	endfunction

	task automatic drain_output();
		int waited;
		waited    = 0;
		out_ready = 1'b1;
		while (!queues_empty() && waited < DRAIN_CYCLES) begin
			@(posedge clk125);
			waited++;
		end
		// Catch stray words after the last expected one
		repeat (IDLE_CYCLES) @(posedge clk125);
		for (int l = 0; l < LANE_COUNT; l++) begin
			if (exp_q[l].size() != 0) begin
				$display("Lane %0d still has %0d expected words that never came out",
					l, exp_q[l].size());
				other_errors++;
			end
		end
	endtask

	// --------------------------------------------------
	// Output monitor
	// --------------------------------------------------
	// Sampled half a cycle before the transfer edge
	always @(negedge clk125) begin
		if (!sys_rst && out_valid && out_ready) begin
			if (exp_q[out_lane].size() == 0) begin
				$display("Word on lane %0d arrived with no expected word left at %0t",
					out_lane, $time);
				other_errors++;
			end else begin
				mon_entry = exp_q[out_lane].pop_front();
				check_value("out_word", 32'(out_word), 32'(mon_entry[28:0]));
				check_value("out_kind", 32'(out_kind), 32'(mon_entry[29]));
			end
		end
	end

	initial begin
		wait (vectors_loaded);
		repeat (n_frames * (int'(PAYLOAD_END) + 40) + 1000) @(posedge clk125);
		$display("Timeout: the run did not finish in the expected number of cycles");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		sys_rst    = 1'b1;
		rxd        = 8'h00;
		rx_dv      = 1'b0;
		out_ready  = 1'b1;
		ready_lfsr = LFSR_SEED;
		load_vectors();
		vectors_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk125);
		#(DRIVE_DELAY);
		sys_rst = 1'b0;
		for (int f = 0; f < n_frames; f++) begin
			build_frame(f);
			expect_words(f);
			drive_frame(vec[f][C_MODE]);
			check_value("drop_count", 32'(drop_count), 32'(exp_drops));
		end
		drain_output();
		$display("Error counts: %0d value mismatches, %0d other errors",
			check_errors, other_errors);
		if (check_errors == 0 && other_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* gmii_av_rx.f */
src/av_net_pkg.sv
src/av_stream_pkg.sv
src/gmii_rx_align.sv
src/av_packet_parser.sv
src/av_lane_merge.sv
src/gmii_av_rx.sv
dv/gmii_av_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the gmii_av_rx testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f gmii_av_rx.f --top-module gmii_av_rx_tb \
	-Mdir obj_dir -o gmii_av_rx_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build returned status $status"
	exit 1
fi

./obj_dir/gmii_av_rx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation binary returned status $status"
	exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
else
	exit 1
fi

/* dv/gmii_av_rx_vectors.txt */
# ofs port etype proto kind line field seed (hex)  ready_mode accept cut (decimal)
# cut is the number of bytes sent, 0 sends the whole frame with its FCS
0 3039 0800 11 00 010 0 0001 0 1 0
1 3039 0800 11 00 123 1 0002 0 1 0
2 3039 0800 11 00 7ff 0 0003 0 1 0
3 3039 0800 11 00 400 1 0004 0 1 0
0 3039 0800 11 01 000 0 0005 0 1 0
1 3039 0800 11 01 000 0 0006 0 1 0
2 3039 0800 11 01 000 0 0007 0 1 0
3 3039 0800 11 01 000 0 0008 0 1 0
1 3039 86dd 11 00 055 0 0009 0 0 0
2 3039 0800 06 00 056 0 000a 0 0 0
0 3038 0800 11 01 000 0 000b 0 0 0
4 3039 0800 11 00 058 0 000d 0 0 0
7 3039 0800 11 01 000 0 000e 0 0 0
0 3039 0800 11 02 000 0 000f 0 0 0
1 3039 0800 11 00 059 0 0010 0 0 30
2 3039 0800 11 00 1a5 1 0011 0 1 400
2 3039 0800 11 00 1a6 0 0012 0 1 0
3 3039 0800 11 01 000 0 0013 0 1 700
3 3039 0800 11 01 000 0 0014 0 1 0
0 3039 0800 11 00 2b0 0 0015 1 1 0
1 3039 0800 11 01 000 0 0016 1 1 0
3 3039 0800 11 00 2b1 1 0017 1 1 0
0 3039 0800 11 00 3c0 0 0018 2 1 0
2 3039 0800 11 01 000 0 0019 0 1 0
3 3039 0800 11 01 000 0 001a 2 1 0
1 3039 0800 11 00 3c1 1 001b 1 1 0
2 3039 0800 11 01 000 0 001c 1 1 0
